/* all.f */
+incdir+include
design/linkbank_pkg.sv
design/list_append.sv
design/slot_store.sv
design/list_release.sv
design/linkbank_top.sv
sim/linkbank_tb.sv

/* design/linkbank_pkg.sv */
// ############################
// Types shared by the message bank blocks
// All request structs are single-cycle strobes qualified by en
// ############################
`default_nettype none

`include "linkbank_macros.svh"

package linkbank_pkg;

  typedef logic [`LB_ID_W-1:0] id_t;
  typedef logic [`LB_SLOT_W-1:0] slot_t;
  typedef logic [`LB_PAYLOAD_W-1:0] payload_t;

  // Message as seen on the input and output ports
  typedef struct packed {
    id_t      id;
    payload_t payload;
  } msg_t;

  // Store a payload and mark the slot occupied
  typedef struct packed {
    logic     en;
    slot_t    slot;
    payload_t payload;
  } slot_write_t;

  // Write one next pointer
  typedef struct packed {
    logic  en;
    slot_t slot;
    slot_t next;
  } link_write_t;

  // Append notice to the consumer side
  typedef struct packed {
    logic  en;
    id_t   id;
    slot_t slot;
    logic  starts_list;
  } list_start_t;

  // Release one slot back to the pool
  typedef struct packed {
    logic  en;
    slot_t slot;
  } slot_free_t;

endpackage

`default_nettype wire

/* design/linkbank_top.sv */
// ############################
// Linked-list message bank, 16 shared slots and 4 FIFO lists
// Output selection comes from outside as a one-hot vector
// ############################
`timescale 1ns/100ps
`default_nettype none

`include "linkbank_macros.svh"

module linkbank_top (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       in_valid_i,
  input  wire linkbank_pkg::msg_t         in_msg_i,
  output logic                            in_ready_o,
  input  wire logic [`LB_NUM_IDS-1:0]     release_onehot_i,
  input  wire logic                       out_ready_i,
  output logic                            out_valid_o,
  output linkbank_pkg::msg_t              out_msg_o
);

  logic [`LB_NUM_SLOTS-1:0]  occupied;
  logic [`LB_NUM_IDS-1:0]    list_survives;
  linkbank_pkg::slot_write_t slot_write;
  linkbank_pkg::link_write_t link_write;
  linkbank_pkg::list_start_t list_start;
  linkbank_pkg::slot_free_t  slot_free;
  linkbank_pkg::slot_t       rd_slot;
  linkbank_pkg::payload_t    rd_payload;
  linkbank_pkg::slot_t       rd_next;

  list_append u_list_append (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .in_valid_i      (in_valid_i),
    .in_msg_i        (in_msg_i),
    .occupied_i      (occupied),
    .list_survives_i (list_survives),
    .in_ready_o      (in_ready_o),
    .slot_write_o    (slot_write),
    .link_write_o    (link_write),
    .list_start_o    (list_start)
  );

  slot_store u_slot_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .slot_write_i (slot_write),
    .link_write_i (link_write),
    .slot_free_i  (slot_free),
    .rd_slot_i    (rd_slot),
    .occupied_o   (occupied),
    .rd_payload_o (rd_payload),
    .rd_next_o    (rd_next)
  );

  list_release u_list_release (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .release_onehot_i (release_onehot_i),
    .out_ready_i      (out_ready_i),
    .list_start_i     (list_start),
    .rd_payload_i     (rd_payload),
    .rd_next_i        (rd_next),
    .out_valid_o      (out_valid_o),
    .out_msg_o        (out_msg_o),
    .rd_slot_o        (rd_slot),
    .slot_free_o      (slot_free),
    .list_survives_o  (list_survives)
  );

endmodule

`default_nettype wire

/* design/list_append.sv */
// ############################
// Producer side of the message bank
// Requests are combinational in the acceptance cycle
// list_survives_i must already account for this cycle's pop
// ############################
`timescale 1ns/100ps
`default_nettype none

`include "linkbank_macros.svh"

module list_append (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic                         in_valid_i,
  input  wire linkbank_pkg::msg_t           in_msg_i,
  input  wire logic [`LB_NUM_SLOTS-1:0]     occupied_i,
  input  wire logic [`LB_NUM_IDS-1:0]       list_survives_i,
  output logic                              in_ready_o,
  output linkbank_pkg::slot_write_t         slot_write_o,
  output linkbank_pkg::link_write_t         link_write_o,
  output linkbank_pkg::list_start_t         list_start_o
);

  linkbank_pkg::slot_t tails_q [`LB_NUM_IDS];
  linkbank_pkg::slot_t free_slot;
  logic                any_free;
  logic                accept;
  logic                survives;

  // Lowest free slot wins, so scan downwards and keep the last hit
  always_comb begin
    free_slot = '0;
    any_free  = 1'b0;
    for (int s = `LB_NUM_SLOTS - 1; s >= 0; s--) begin
      if (!occupied_i[s]) begin
        free_slot = linkbank_pkg::slot_t'(s);
        any_free  = 1'b1;
      end
    end
  end

  // Only registered occupancy here, never in_valid_i
  assign in_ready_o = any_free;
  assign accept     = in_valid_i && in_ready_o;
  assign survives   = list_survives_i[in_msg_i.id];

  always_comb begin
    slot_write_o.en      = accept;
    slot_write_o.slot    = free_slot;
    slot_write_o.payload = in_msg_i.payload;

    // Chain behind the old tail only if that list outlives this cycle
    link_write_o.en   = accept && survives;
    link_write_o.slot = tails_q[in_msg_i.id];
    link_write_o.next = free_slot;

    list_start_o.en          = accept;
    list_start_o.id          = in_msg_i.id;
    list_start_o.slot        = free_slot;
    list_start_o.starts_list = !survives;
  end

  // New message always becomes the tail of its ID
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `LB_NUM_IDS; i++) begin
        tails_q[i] <= '0;
      end
    end else if (accept) begin
      tails_q[in_msg_i.id] <= free_slot;
    end
  end

endmodule

`default_nettype wire

/* design/list_release.sv */
// ############################
// Consumer side of the message bank
// release_onehot_i must be one-hot or zero
// Output is combinational from the head registers
// ############################
`timescale 1ns/100ps
`default_nettype none

`include "linkbank_macros.svh"

module list_release (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire logic [`LB_NUM_IDS-1:0]       release_onehot_i,
  input  wire logic                         out_ready_i,
  input  wire linkbank_pkg::list_start_t    list_start_i,
  input  wire linkbank_pkg::payload_t       rd_payload_i,
  input  wire linkbank_pkg::slot_t          rd_next_i,
  output logic                              out_valid_o,
  output linkbank_pkg::msg_t                out_msg_o,
  output linkbank_pkg::slot_t               rd_slot_o,
  output linkbank_pkg::slot_free_t          slot_free_o,
  output logic [`LB_NUM_IDS-1:0]            list_survives_o
);

  linkbank_pkg::slot_t    heads_q [`LB_NUM_IDS];
  logic [`LB_CNT_W-1:0]   len_q   [`LB_NUM_IDS];
  logic [`LB_CNT_W-1:0]   len_after_pop [`LB_NUM_IDS];
  linkbank_pkg::id_t      sel_id;
  logic                   pop;
  logic [`LB_NUM_IDS-1:0] pop_vec;
  logic [`LB_NUM_IDS-1:0] push_vec;

  // One-hot to binary, OR of the set positions
  always_comb begin
    sel_id = '0;
    for (int i = 0; i < `LB_NUM_IDS; i++) begin
      if (release_onehot_i[i]) begin
        sel_id = sel_id | linkbank_pkg::id_t'(i);
      end
    end
  end

  // A zero select leaves out_valid_o low
  assign out_valid_o       = (|release_onehot_i) && (len_q[sel_id] != '0);
  assign rd_slot_o         = heads_q[sel_id];
  assign out_msg_o.id      = sel_id;
  assign out_msg_o.payload = rd_payload_i;
  assign pop               = out_valid_o && out_ready_i;

  assign slot_free_o.en   = pop;
  assign slot_free_o.slot = heads_q[sel_id];

  always_comb begin
    for (int i = 0; i < `LB_NUM_IDS; i++) begin
      pop_vec[i]  = pop && (sel_id == linkbank_pkg::id_t'(i));
      push_vec[i] = list_start_i.en && (list_start_i.id == linkbank_pkg::id_t'(i));
      len_after_pop[i] = len_q[i] - {{(`LB_CNT_W-1){1'b0}}, pop_vec[i]};
      // Producer links behind the old tail only while this is set
      list_survives_o[i] = len_after_pop[i] != '0;
    end
  end

  // A restarting append overrides the head advance of a same-cycle pop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `LB_NUM_IDS; i++) begin
        heads_q[i] <= '0;
        len_q[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < `LB_NUM_IDS; i++) begin
        len_q[i] <= len_after_pop[i] + {{(`LB_CNT_W-1){1'b0}}, push_vec[i]};
        if (push_vec[i] && list_start_i.starts_list) begin
          heads_q[i] <= list_start_i.slot;
        end else if (pop_vec[i]) begin
          heads_q[i] <= rd_next_i;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* design/slot_store.sv */
// ############################
// Slot pool with payload, next pointer and occupancy per slot
// Reads are combinational, writes and frees land at the edge
// A write and a free never target the same slot in one cycle
// ############################
`timescale 1ns/100ps
`default_nettype none

`include "linkbank_macros.svh"

module slot_store (
  input  wire logic                         clk_i,
  input  wire logic                         rst_ni,
  input  wire linkbank_pkg::slot_write_t    slot_write_i,
  input  wire linkbank_pkg::link_write_t    link_write_i,
  input  wire linkbank_pkg::slot_free_t     slot_free_i,
  input  wire linkbank_pkg::slot_t          rd_slot_i,
  output logic [`LB_NUM_SLOTS-1:0]          occupied_o,
  output linkbank_pkg::payload_t            rd_payload_o,
  output linkbank_pkg::slot_t               rd_next_o
);

  linkbank_pkg::payload_t payload_q [`LB_NUM_SLOTS];
  linkbank_pkg::slot_t    next_q    [`LB_NUM_SLOTS];
  logic [`LB_NUM_SLOTS-1:0] occupied_q;
  logic [`LB_NUM_SLOTS-1:0] set_mask;
  logic [`LB_NUM_SLOTS-1:0] clr_mask;

  // Payload and link storage
  always_ff @(posedge clk_i) begin
    if (slot_write_i.en) begin
      payload_q[slot_write_i.slot] <= slot_write_i.payload;
    end
    if (link_write_i.en) begin
      next_q[link_write_i.slot] <= link_write_i.next;
    end
  end

  // Plain set and clear strobes per slot
  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    if (slot_write_i.en) begin
      set_mask[slot_write_i.slot] = 1'b1;
    end
    if (slot_free_i.en) begin
      clr_mask[slot_free_i.slot] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= '0;
    end else begin
      occupied_q <= (occupied_q | set_mask) & ~clr_mask;
    end
  end

  assign occupied_o   = occupied_q;
  assign rd_payload_o = payload_q[rd_slot_i];
  assign rd_next_o    = next_q[rd_slot_i];

endmodule

`default_nettype wire

/* include/linkbank_macros.svh */
// ############################
// Sizing constants for the linked-list message bank
// LB_SLOT_W must cover LB_NUM_SLOTS and LB_ID_W must cover LB_NUM_IDS
// LB_CNT_W needs one bit more than LB_SLOT_W so a full pool fits one list
// ############################
`ifndef LINKBANK_MACROS_SVH
`define LINKBANK_MACROS_SVH

// Message identifiers, one linked list each
`define LB_NUM_IDS 4
`define LB_ID_W 2

// Shared slot pool
`define LB_NUM_SLOTS 16
`define LB_SLOT_W 4

// Per-list length counter
`define LB_CNT_W 5

// Message body without its ID
`define LB_PAYLOAD_W 16

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the message bank testbench with Verilator.
# Exit status is 0 only when the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f all.f --top-module linkbank_tb -Mdir obj_dir -o linkbank_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/linkbank_sim)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Decide on the pass line itself
if printf '%s\n' "$output" | grep -qx "All checks passed"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* sim/linkbank_tb.sv */
// ############################
// Testbench for the linked-list message bank
// Directed table first, then 400 LFSR cycles against a per-ID queue model
// Inputs change on the falling edge and outputs are sampled 5 ns later
// ############################
`timescale 1ns/100ps
`default_nettype none

`include "linkbank_macros.svh"

module linkbank_tb;

  localparam int RAND_CYCLES = 400;

  typedef struct packed {
    logic                     vld;
    linkbank_pkg::id_t        id;
    linkbank_pkg::payload_t   payload;
    logic [`LB_NUM_IDS-1:0]   sel;
    logic                     rdy;
    logic                     exp_valid;
    linkbank_pkg::msg_t       exp_msg;
    logic                     exp_ready;
  } row_t;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   in_valid_i;
  linkbank_pkg::msg_t     in_msg_i;
  logic                   in_ready_o;
  logic [`LB_NUM_IDS-1:0] release_onehot_i;
  logic                   out_ready_i;
  logic                   out_valid_o;
  linkbank_pkg::msg_t     out_msg_o;

  row_t rows [$];
  int   dut_err_cnt = 0;
  int   table_err_cnt = 0;
  int   cycle_cnt = 0;
  int   cycle_limit = 0;
  logic [31:0] lfsr = 32'h7729;

  // Circular queue per ID
  linkbank_pkg::payload_t mdl_data [`LB_NUM_IDS][`LB_NUM_SLOTS];
  linkbank_pkg::slot_t    mdl_head [`LB_NUM_IDS];
  logic [`LB_CNT_W-1:0]   mdl_cnt  [`LB_NUM_IDS];
  logic [`LB_CNT_W-1:0]   mdl_total;

  // Expected message of the previous cycle while the output stalls
  logic                   hold_valid = 1'b0;
  logic [`LB_NUM_IDS-1:0] hold_sel;
  linkbank_pkg::msg_t     hold_msg;

  linkbank_top u_linkbank_top (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .in_valid_i       (in_valid_i),
    .in_msg_i         (in_msg_i),
    .in_ready_o       (in_ready_o),
    .release_onehot_i (release_onehot_i),
    .out_ready_i      (out_ready_i),
    .out_valid_o      (out_valid_o),
    .out_msg_o        (out_msg_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic linkbank_pkg::id_t sel_to_id(input logic [`LB_NUM_IDS-1:0] sel);
    case (sel)
      4'b0010: return 2'd1;
      4'b0100: return 2'd2;
      4'b1000: return 2'd3;
      default: return 2'd0;
    endcase
  endfunction

  function automatic logic model_valid(input logic [`LB_NUM_IDS-1:0] sel);
    return (sel != 4'b0000) && (mdl_cnt[sel_to_id(sel)] != 5'd0);
  endfunction

  function automatic linkbank_pkg::msg_t model_msg(input logic [`LB_NUM_IDS-1:0] sel);
    linkbank_pkg::msg_t m;
    m.id      = sel_to_id(sel);
    m.payload = mdl_data[m.id][mdl_head[m.id]];
    return m;
  endfunction

  // Acceptance sees the pool before this cycle's pop
  task automatic model_step(input logic vld, input linkbank_pkg::id_t id,
                            input linkbank_pkg::payload_t pay,
                            input logic [`LB_NUM_IDS-1:0] sel, input logic rdy);
    linkbank_pkg::id_t   sid;
    linkbank_pkg::slot_t wr_ptr;
    logic                pop;
    logic                push;
    sid  = sel_to_id(sel);
    pop  = model_valid(sel) && rdy;
    push = vld && (mdl_total != 5'd16);
    if (pop) begin
      mdl_head[sid] = mdl_head[sid] + 4'd1;
      mdl_cnt[sid]  = mdl_cnt[sid] - 5'd1;
      mdl_total     = mdl_total - 5'd1;
    end
    if (push) begin
      wr_ptr               = mdl_head[id] + mdl_cnt[id][3:0];
      mdl_data[id][wr_ptr] = pay;
      mdl_cnt[id]          = mdl_cnt[id] + 5'd1;
      mdl_total            = mdl_total + 5'd1;
    end
  endtask

  task automatic add_row(input logic vld, input linkbank_pkg::id_t id,
                         input linkbank_pkg::payload_t pay, input logic [3:0] sel,
                         input logic rdy, input logic ev, input linkbank_pkg::id_t eid,
                         input linkbank_pkg::payload_t epay, input logic er);
    row_t row;
    row.vld               = vld;
    row.id                = id;
    row.payload           = pay;
    row.sel               = sel;
    row.rdy               = rdy;
    row.exp_valid         = ev;
    row.exp_msg.id        = eid;
    row.exp_msg.payload   = epay;
    row.exp_ready         = er;
    rows.push_back(row);
  endtask

  task automatic drive_cycle(input logic vld, input linkbank_pkg::id_t id,
                             input linkbank_pkg::payload_t pay,
                             input logic [`LB_NUM_IDS-1:0] sel, input logic rdy);
    @(negedge clk_i);
    in_valid_i         = vld;
    in_msg_i.id        = id;
    in_msg_i.payload   = pay;
    release_onehot_i   = sel;
    out_ready_i        = rdy;
    #5;
  endtask

  task automatic check_outputs(input logic exp_valid, input linkbank_pkg::msg_t exp_msg,
                               input logic exp_ready);
    assert (out_valid_o === exp_valid) else begin
      $display("Fail out_valid_o: got %h, expected %h", out_valid_o, exp_valid);
      dut_err_cnt++;
    end
    assert (in_ready_o === exp_ready) else begin
      $display("Fail in_ready_o: got %h, expected %h", in_ready_o, exp_ready);
      dut_err_cnt++;
    end
    if (exp_valid) begin
      assert (out_msg_o === exp_msg) else begin
        $display("Fail out_msg_o: got %h, expected %h", out_msg_o, exp_msg);
        dut_err_cnt++;
      end
    end
    if (hold_valid && release_onehot_i == hold_sel) begin
      assert (out_msg_o === hold_msg) else begin
        $display("Fail out_msg_o while stalled: got %h, held %h", out_msg_o, hold_msg);
        dut_err_cnt++;
      end
    end
    hold_valid = exp_valid && !out_ready_i;
    hold_sel   = release_onehot_i;
    hold_msg   = exp_msg;
  endtask

  // Table rows must agree with the queue model too
  task automatic check_table_row(input int r, input row_t row);
    assert (row.exp_valid === model_valid(row.sel)) else begin
      $display("Fail row %0d out_valid_o: table %h, model %h", r, row.exp_valid,
               model_valid(row.sel));
      table_err_cnt++;
    end
    assert (row.exp_ready === (mdl_total != 5'd16)) else begin
      $display("Fail row %0d in_ready_o: table %h, model %h", r, row.exp_ready,
               mdl_total != 5'd16);
      table_err_cnt++;
    end
    if (row.exp_valid) begin
      assert (row.exp_msg === model_msg(row.sel)) else begin
        $display("Fail row %0d out_msg_o: table %h, model %h", r, row.exp_msg,
                 model_msg(row.sel));
        table_err_cnt++;
      end
    end
  endtask

  task automatic build_table();
    linkbank_pkg::id_t      lid;
    logic [`LB_NUM_IDS-1:0] lsel;
    logic [4:0]             n;
    // Empty after reset for every select and for none
    for (int k = 0; k < 5; k++) begin
      add_row(1'b0, 2'd0, 16'h0, 4'b0001 << k, 1'b1, 1'b0, 2'd0, 16'h0, 1'b1);
    end
    // Interleaved pushes and then a drain of each ID in turn
    for (n = 5'd0; n < 5'd8; n++) begin
      add_row(1'b1, n[1:0], {11'h500, n}, 4'b0000, 1'b0, 1'b0, 2'd0, 16'h0, 1'b1);
    end
    for (int k = 0; k < 4; k++) begin
      lid  = 2'd3 - k[1:0];
      lsel = 4'b0001 << lid;
      add_row(1'b0, 2'd0, 16'h0, lsel, 1'b1, 1'b1, lid, {11'h500, 3'b000, lid}, 1'b1);
      add_row(1'b0, 2'd0, 16'h0, lsel, 1'b1, 1'b1, lid, {11'h500, 3'b001, lid}, 1'b1);
      add_row(1'b0, 2'd0, 16'h0, lsel, 1'b1, 1'b0, 2'd0, 16'h0, 1'b1);
    end
    // Same-cycle push and pop on ID 1 with two pops of a single-entry list
    add_row(1'b1, 2'd1, 16'h1111, 4'b0010, 1'b0, 1'b0, 2'd0, 16'h0, 1'b1);
    add_row(1'b1, 2'd1, 16'h2222, 4'b0010, 1'b1, 1'b1, 2'd1, 16'h1111, 1'b1);
    add_row(1'b1, 2'd1, 16'h3333, 4'b0010, 1'b1, 1'b1, 2'd1, 16'h2222, 1'b1);
    add_row(1'b1, 2'd1, 16'h4444, 4'b0010, 1'b0, 1'b1, 2'd1, 16'h3333, 1'b1);
    add_row(1'b1, 2'd1, 16'h5555, 4'b0010, 1'b1, 1'b1, 2'd1, 16'h3333, 1'b1);
    add_row(1'b0, 2'd0, 16'h0, 4'b0010, 1'b1, 1'b1, 2'd1, 16'h4444, 1'b1);
    add_row(1'b0, 2'd0, 16'h0, 4'b0010, 1'b1, 1'b1, 2'd1, 16'h5555, 1'b1);
    add_row(1'b0, 2'd0, 16'h0, 4'b0010, 1'b1, 1'b0, 2'd0, 16'h0, 1'b1);
    // Fill all 16 slots and then free slot 0 and reuse it
    for (n = 5'd0; n < 5'd16; n++) begin
      add_row(1'b1, n[1:0], {11'h200, n}, 4'b0000, 1'b0, 1'b0, 2'd0, 16'h0, 1'b1);
    end
    add_row(1'b1, 2'd0, 16'hBEEF, 4'b0001, 1'b0, 1'b1, 2'd0, 16'h4000, 1'b0);
    add_row(1'b0, 2'd0, 16'h0, 4'b0001, 1'b1, 1'b1, 2'd0, 16'h4000, 1'b0);
    add_row(1'b1, 2'd0, 16'h4F00, 4'b0001, 1'b0, 1'b1, 2'd0, 16'h4004, 1'b1);
    add_row(1'b1, 2'd2, 16'h5555, 4'b0000, 1'b0, 1'b0, 2'd0, 16'h0, 1'b0);
    add_row(1'b0, 2'd0, 16'h0, 4'b0001, 1'b1, 1'b1, 2'd0, 16'h4004, 1'b0);
    add_row(1'b0, 2'd0, 16'h0, 4'b0001, 1'b1, 1'b1, 2'd0, 16'h4008, 1'b1);
    add_row(1'b0, 2'd0, 16'h0, 4'b0001, 1'b1, 1'b1, 2'd0, 16'h400C, 1'b1);
    add_row(1'b0, 2'd0, 16'h0, 4'b0001, 1'b1, 1'b1, 2'd0, 16'h4F00, 1'b1);
    // Stall on ID 1 with a push behind it and then empty and zero selects
    add_row(1'b0, 2'd0, 16'h0, 4'b0010, 1'b0, 1'b1, 2'd1, 16'h4001, 1'b1);
    add_row(1'b1, 2'd1, 16'h6001, 4'b0010, 1'b0, 1'b1, 2'd1, 16'h4001, 1'b1);
    add_row(1'b0, 2'd0, 16'h0, 4'b0010, 1'b0, 1'b1, 2'd1, 16'h4001, 1'b1);
    add_row(1'b0, 2'd0, 16'h0, 4'b0010, 1'b1, 1'b1, 2'd1, 16'h4001, 1'b1);
    add_row(1'b0, 2'd0, 16'h0, 4'b0010, 1'b1, 1'b1, 2'd1, 16'h4005, 1'b1);
    add_row(1'b0, 2'd0, 16'h0, 4'b0001, 1'b1, 1'b0, 2'd0, 16'h0, 1'b1);
    add_row(1'b0, 2'd0, 16'h0, 4'b0000, 1'b1, 1'b0, 2'd0, 16'h0, 1'b1);
  endtask

  initial begin
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Checks failed");
    $finish;
  end

  initial begin
    row_t                   row;
    logic [31:0]            bits;
    logic                   vld;
    logic                   rdy;
    linkbank_pkg::id_t      rid;
    linkbank_pkg::payload_t rpay;
    logic [`LB_NUM_IDS-1:0] rsel;
    rst_ni           = 1'b0;
    in_valid_i       = 1'b0;
    in_msg_i         = '0;
    release_onehot_i = '0;
    out_ready_i      = 1'b0;
    mdl_head         = '{default: '0};
    mdl_cnt          = '{default: '0};
    mdl_total        = '0;
    build_table();
    cycle_limit = rows.size() + RAND_CYCLES + 50;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int r = 0; r < rows.size(); r++) begin
      row = rows[r];
      drive_cycle(row.vld, row.id, row.payload, row.sel, row.rdy);
      check_table_row(r, row);
      check_outputs(row.exp_valid, row.exp_msg, row.exp_ready);
      model_step(row.vld, row.id, row.payload, row.sel, row.rdy);
    end

    // Mostly valid inputs so the pool fills and back-pressure shows up
    for (int c = 0; c < RAND_CYCLES; c++) begin
      draw_bits(2, bits);
      vld = (bits[1:0] != 2'b00);
      draw_bits(2, bits);
      rid = bits[1:0];
      draw_bits(16, bits);
      rpay = bits[15:0];
      draw_bits(3, bits);
      rsel = (bits[2:0] == 3'd7) ? 4'b0000 : 4'b0001 << bits[1:0];
      draw_bits(1, bits);
      rdy = bits[0];
      drive_cycle(vld, rid, rpay, rsel, rdy);
      check_outputs(model_valid(rsel), model_msg(rsel), mdl_total != 5'd16);
      model_step(vld, rid, rpay, rsel, rdy);
    end

    $display("Error counts: %0d against the DUT, %0d in the table", dut_err_cnt,
             table_err_cnt);
    if (dut_err_cnt == 0 && table_err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
